// File: compile.f
ps2_kbd_pkg.sv
seg7_decoder.sv
display_config.sv
scan_decoder.sv
ps2_receiver.sv
ps2_display_top.sv
ps2_display_assertions.sv
tb_ps2_display.sv

// File: Bender.yml
package:
  name: ps2_display

sources:
  - ps2_kbd_pkg.sv
  - seg7_decoder.sv
  - display_config.sv
  - scan_decoder.sv
  - ps2_receiver.sv
  - ps2_display_top.sv
  - target: test
    files:
      - ps2_display_assertions.sv
      - tb_ps2_display.sv

// File: tb_ps2_display.sv
`timescale 1ns/1ps

module tb_ps2_display;
    import ps2_kbd_pkg::*;

    localparam int     N_TESTS     = 6;
    localparam int     MAX_BYTES   = 8;
    localparam int     BIT_CYCLES  = 40;
    localparam int     WAIT_LIMIT  = 400;
    localparam longint WATCHDOG_NS = 2 * N_TESTS * 8 * 11 * 80 * 8;

    logic       clk = 1'b0;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic       cfg_we;
    cfg_t       cfg_wdata;
    seg_t       seg_lo;
    seg_t       seg_hi;
    scan_code_t key_code;
    logic       key_strobe;
    err_count_t err_count;

    // Stimulus table, one entry per test. Byte i of a sequence sits at bits 8*i+7 to 8*i.
    string      names       [N_TESTS];
    disp_mode_t modes       [N_TESTS];
    logic       blanks      [N_TESTS];
    int         n_bytes     [N_TESTS];
    logic [63:0] seqs       [N_TESTS];
    logic [7:0] bad         [N_TESTS];
    int         gaps        [N_TESTS];
    scan_code_t exp_codes   [N_TESTS];
    int         exp_strobes [N_TESTS];
    err_count_t exp_err     [N_TESTS];

    int         n_rows = 0;
    int         mismatches = 0;
    int         other_errors = 0;
    int         first;
    logic       shown = 1'b0;
    scan_code_t seen [$]; // Codes captured at each strobe.

    ps2_display_top #(
        .FIFO_DEPTH (4),
        .CREDITS    (2)
    ) u_ps2_display_top (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .cfg_we     (cfg_we),
        .cfg_wdata  (cfg_wdata),
        .seg_lo     (seg_lo),
        .seg_hi     (seg_hi),
        .key_code   (key_code),
        .key_strobe (key_strobe),
        .err_count  (err_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        if (rst && key_strobe)
            seen.push_back(key_code);
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run timed out.");
        $display("STATUS: FAIL");
        $finish;
    end

    // Active-low patterns for the usual digit shapes, decimal point dark.
    function automatic seg_t seg_pattern(input hex_digit_t d);
        case (d)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    task automatic check_code(input string name, input scan_code_t exp, input scan_code_t act);
        if (exp !== act)
        begin
            $display("Mismatch %s: key_code expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (exp !== act)
        begin
            $display("Mismatch %s: segments expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_err(input string name, input err_count_t exp, input err_count_t act);
        if (exp !== act)
        begin
            $display("Mismatch %s: err_count expected %0d, got %0d", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("Mismatch %s: strobe count expected %0d, got %0d", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic add_row(input string name, input disp_mode_t mode, input logic blank,
                           input int n, input logic [63:0] seq, input logic [7:0] corrupt,
                           input int gap, input scan_code_t code, input int strobes,
                           input err_count_t errs);
        names[n_rows]       = name;
        modes[n_rows]       = mode;
        blanks[n_rows]      = blank;
        n_bytes[n_rows]     = n;
        seqs[n_rows]        = seq;
        bad[n_rows]         = corrupt;
        gaps[n_rows]        = gap;
        exp_codes[n_rows]   = code;
        exp_strobes[n_rows] = strobes;
        exp_err[n_rows]     = errs;
        n_rows++;
    endtask

    // Start bit, data LSB first, odd parity, stop bit. Data changes while ps2_clk is high.
    task automatic send_frame(input scan_code_t code, input logic corrupt);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^code) ^ corrupt, code, 1'b0};
        @(posedge clk);
        for (i = 0; i < 11; i++)
        begin
            ps2_dat <= bits[i];
            repeat (BIT_CYCLES / 2) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (BIT_CYCLES / 2) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        ps2_dat <= 1'b1;
    endtask

    task automatic wait_for_dut(input int t);
        int cycles;
        cycles = 0;
        while (((seen.size() - first) < exp_strobes[t] || err_count != exp_err[t])
               && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT)
        begin
            $display("Test %s: the DUT did not finish the frames in time.", names[t]);
            other_errors++;
        end
        repeat (20) @(posedge clk); // Late extra strobes would show up here.
    endtask

    task automatic run_test(input int t);
        int   i;
        seg_t exp_lo;
        seg_t exp_hi;
        first = seen.size();
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_wdata <= {modes[t], blanks[t]};
        @(posedge clk);
        cfg_we <= 1'b0;
        for (i = 0; i < n_bytes[t]; i++)
        begin
            send_frame(seqs[t][8*i +: 8], bad[t][i]);
            repeat (gaps[t]) @(posedge clk);
        end
        wait_for_dut(t);
        if (exp_strobes[t] > 0)
            shown = 1'b1;
        exp_lo = (blanks[t] || !shown) ? 8'hFF : seg_pattern(exp_codes[t][3:0]);
        exp_hi = (blanks[t] || !shown) ? 8'hFF : seg_pattern(exp_codes[t][7:4]);
        check_count(names[t], exp_strobes[t], seen.size() - first);
        check_code(names[t], exp_codes[t], key_code);
        check_seg({names[t], " seg_lo"}, exp_lo, seg_lo);
        check_seg({names[t], " seg_hi"}, exp_hi, seg_hi);
        check_err(names[t], exp_err[t], err_count);
        // When every byte is a shown make code, the strobes must follow the byte order.
        if (exp_strobes[t] == n_bytes[t])
            for (i = 0; i < n_bytes[t] && first + i < seen.size(); i++)
                check_code({names[t], " order"}, seqs[t][8*i +: 8], seen[first + i]);
    endtask

    initial
    begin
        logic [63:0] rand_seq;
        scan_code_t  code;
        int          t;
        rst       = 1'b0;
        ps2_clk   = 1'b1;
        ps2_dat   = 1'b1;
        cfg_we    = 1'b0;
        cfg_wdata = '0;
        void'($urandom(32'hbcafe374));
        for (t = 0; t < MAX_BYTES; t++)
        begin
            code = 8'hF0;
            while (code == 8'hF0)
                code = scan_code_t'($urandom);
            rand_seq[8*t +: 8] = code;
        end
        // The trailing 1B is never released, so only press mode would show it.
        add_row("release_mode", SHOW_ON_RELEASE, 1'b0, 4, 64'h1B1CF01C, 8'h00, 40,
                8'h1C, 1, 8'd0);
        add_row("press_mode", SHOW_ON_PRESS, 1'b0, 3, 64'h32F032, 8'h00, 40, 8'h32, 1, 8'd0);
        add_row("bad_parity", SHOW_ON_PRESS, 1'b0, 1, 64'h4B, 8'h01, 40, 8'h32, 0, 8'd1);
        add_row("blank_on", SHOW_ON_PRESS, 1'b1, 1, 64'h5A, 8'h00, 40, 8'h5A, 1, 8'd1);
        add_row("blank_off", SHOW_ON_PRESS, 1'b0, 0, 64'h0, 8'h00, 40, 8'h5A, 0, 8'd1);
        add_row("back_to_back", SHOW_ON_PRESS, 1'b0, 8, rand_seq, 8'h00, 0,
                rand_seq[63:56], 8, 8'd1);
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        check_code("after_reset", 8'h00, key_code);
        check_seg("after_reset seg_lo", 8'hFF, seg_lo);
        check_seg("after_reset seg_hi", 8'hFF, seg_hi);
        check_err("after_reset", 8'd0, err_count);
        for (t = 0; t < n_rows; t++)
            run_test(t);
        $display("Error counts: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: ps2_display_assertions.sv
`timescale 1ns/1ps

module ps2_display_assertions #(
    parameter int CREDITS = 2
) (
    input logic                           clk,
    input logic                           rst,
    input logic [$clog2(CREDITS+1)-1:0]   credits,
    input logic                           byte_valid,
    input logic                           key_strobe
);

    // The receiver can never hold more credits than the decoder has buffer slots.
    credit_bound: assert property (@(posedge clk) disable iff (!rst)
        credits <= CREDITS)
        else $error("Credit count %0d is above the limit of %0d.", credits, CREDITS);

    // A byte goes out one cycle after a send that used up a held credit.
    send_needs_credit: assert property (@(posedge clk) disable iff (!rst)
        byte_valid |-> ($past(credits) != 0))
        else $error("A byte was sent while the receiver held no credit.");

    single_strobe: assert property (@(posedge clk) disable iff (!rst)
        key_strobe |=> !key_strobe)
        else $error("key_strobe stayed high for two cycles.");

endmodule

bind ps2_display_top ps2_display_assertions #(
    .CREDITS (CREDITS)
) u_assertions (
    .clk        (clk),
    .rst        (rst),
    .credits    (u_rx.credits),
    .byte_valid (rx_byte.valid),
    .key_strobe (key_strobe)
);

// File: ps2_display_top.sv
`timescale 1ns/1ps

module ps2_display_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int CREDITS    = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ps2_clk,
    input  logic                    ps2_dat,
    input  logic                    cfg_we,
    input  ps2_kbd_pkg::cfg_t       cfg_wdata,
    output ps2_kbd_pkg::seg_t       seg_lo,
    output ps2_kbd_pkg::seg_t       seg_hi,
    output ps2_kbd_pkg::scan_code_t key_code,
    output logic                    key_strobe,
    output ps2_kbd_pkg::err_count_t err_count
);
    import ps2_kbd_pkg::*;

    scan_byte_t rx_byte;
    logic       credit_return;
    cfg_t       cfg;
    logic       key_shown;
    logic       blank;

    ps2_receiver #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CREDITS    (CREDITS)
    ) u_rx (
        .clk           (clk),
        .rst           (rst),
        .ps2_clk       (ps2_clk),
        .ps2_dat       (ps2_dat),
        .credit_return (credit_return),
        .byte_out      (rx_byte),
        .err_count     (err_count)
    );

    scan_decoder #(
        .CREDITS (CREDITS)
    ) u_dec (
        .clk           (clk),
        .rst           (rst),
        .byte_in       (rx_byte),
        .mode          (cfg.mode),
        .credit_return (credit_return),
        .key_code      (key_code),
        .key_shown     (key_shown),
        .key_strobe    (key_strobe)
    );

    display_config u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    // Nothing is shown before the first key.
    assign blank = cfg.blank | ~key_shown;

    seg7_decoder u_seg_lo (
        .digit (key_code[3:0]),
        .blank (blank),
        .seg   (seg_lo)
    );

    seg7_decoder u_seg_hi (
        .digit (key_code[7:4]),
        .blank (blank),
        .seg   (seg_hi)
    );

endmodule

// File: ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver #(
    parameter int FIFO_DEPTH = 4,
    parameter int CREDITS    = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ps2_clk,
    input  logic                    ps2_dat,
    input  logic                    credit_return,
    output ps2_kbd_pkg::scan_byte_t byte_out,
    output ps2_kbd_pkg::err_count_t err_count
);
    import ps2_kbd_pkg::*;

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam int KW = $clog2(CREDITS + 1);

    logic [1:0]    clk_sync;
    logic [1:0]    dat_sync;
    logic          clk_prev;
    logic          fall;
    logic [10:0]   frame;
    logic [3:0]    bit_cnt;
    logic          frame_done;
    logic          frame_ok;
    logic          push;
    logic          pop;
    scan_code_t    mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [KW-1:0] credits;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    // Bits arrive LSB first, so they enter at the top and move down.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= fall && (bit_cnt == 4'd10);
            if (fall)
                bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall)
            frame <= {dat_sync[1], frame[10:1]};
    end

    // Start low, stop high, odd parity over data and parity bit.
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    assign push = frame_done & frame_ok & (count != CW'(FIFO_DEPTH));
    assign pop  = (count != '0) & (credits != '0);

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= frame[8:1];
        if (pop)
            byte_out.code <= mem[rd_ptr];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            credits        <= KW'(CREDITS);
            byte_out.valid <= 1'b0;
            err_count      <= '0;
        end
        else
        begin
            byte_out.valid <= pop;
            if (push)
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count   <= count + CW'(push) - CW'(pop);
            credits <= credits + KW'(credit_return) - KW'(pop);
            if (frame_done && !push && err_count != 8'hFF)
                err_count <= err_count + 8'd1; // Bad frame or FIFO full.
        end
    end

endmodule

// File: scan_decoder.sv
`timescale 1ns/1ps

module scan_decoder #(
    parameter int CREDITS = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  ps2_kbd_pkg::scan_byte_t byte_in,
    input  ps2_kbd_pkg::disp_mode_t mode,
    output logic                    credit_return,
    output ps2_kbd_pkg::scan_code_t key_code,
    output logic                    key_shown,
    output logic                    key_strobe
);
    import ps2_kbd_pkg::*;

    localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CW = $clog2(CREDITS + 1);

    scan_code_t    buf_mem [CREDITS];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;
    scan_code_t    head;
    dec_state_t    state;
    logic          show;

    // The credit scheme keeps the buffer from overflowing.
    always_ff @(posedge clk)
    begin
        if (byte_in.valid)
            buf_mem[wr_ptr] <= byte_in.code;
    end

    assign head = buf_mem[rd_ptr];
    assign pop  = (count != '0) && (state != HOLD); // Nothing is taken while strobing.

    // Decide whether the byte being consumed ends a display event.
    always_comb
    begin
        show = 1'b0;
        if (state == IDLE)
            show = (head != BREAK_PREFIX) && (mode == SHOW_ON_PRESS);
        else if (state == BREAK_WAIT)
            show = (mode == SHOW_ON_RELEASE);
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
            state         <= IDLE;
            key_code      <= '0;
            key_shown     <= 1'b0;
        end
        else
        begin
            credit_return <= pop;
            if (byte_in.valid)
                wr_ptr <= (wr_ptr == PW'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(byte_in.valid) - CW'(pop);

            if (state == HOLD)
                state <= IDLE;
            else if (pop)
            begin
                if (show)
                begin
                    key_code  <= head;
                    key_shown <= 1'b1;
                    state     <= HOLD;
                end
                else if (state == IDLE && head == BREAK_PREFIX)
                    state <= BREAK_WAIT;
                else
                    state <= IDLE;
            end
        end
    end

    assign key_strobe = (state == HOLD);

endmodule

// File: display_config.sv
`timescale 1ns/1ps

module display_config (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_we,
    input  ps2_kbd_pkg::cfg_t cfg_wdata,
    output ps2_kbd_pkg::cfg_t cfg
);
    import ps2_kbd_pkg::*;

    disp_mode_t wr_mode;

    // Encodings other than the two modes fall back to release mode.
    always_comb
    begin
        case (cfg_wdata.mode)
            SHOW_ON_PRESS: wr_mode = SHOW_ON_PRESS;
            default:       wr_mode = SHOW_ON_RELEASE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            cfg.mode  <= SHOW_ON_RELEASE;
            cfg.blank <= 1'b0;
        end
        else if (cfg_we)
        begin
            cfg.mode  <= wr_mode;
            cfg.blank <= cfg_wdata.blank;
        end
    end

endmodule

// File: seg7_decoder.sv
`timescale 1ns/1ps

module seg7_decoder (
    input  ps2_kbd_pkg::hex_digit_t digit,
    input  logic                    blank,
    output ps2_kbd_pkg::seg_t       seg
);

    logic [6:0] lit; // Segments g to a, one means lit.

    always_comb
    begin
        case (digit)
            4'h0:    lit = 7'h3F;
            4'h1:    lit = 7'h06;
            4'h2:    lit = 7'h5B;
            4'h3:    lit = 7'h4F;
            4'h4:    lit = 7'h66;
            4'h5:    lit = 7'h6D;
            4'h6:    lit = 7'h7D;
            4'h7:    lit = 7'h07;
            4'h8:    lit = 7'h7F;
            4'h9:    lit = 7'h6F;
            4'hA:    lit = 7'h77;
            4'hB:    lit = 7'h7C; // Lower case b.
            4'hC:    lit = 7'h39;
            4'hD:    lit = 7'h5E; // Lower case d.
            4'hE:    lit = 7'h79;
            default: lit = 7'h71;
        endcase
    end

    // The display is active low and the decimal point stays dark.
    assign seg = blank ? 8'hFF : {1'b1, ~lit};

endmodule

// File: ps2_kbd_pkg.sv
package ps2_kbd_pkg;

    // One byte as it arrives from the keyboard.
    typedef logic [7:0] scan_code_t;

    // One nibble for one display digit.
    typedef logic [3:0] hex_digit_t;

    // Bit 0 is segment a up to bit 6 segment g, bit 7 the decimal point. Active low.
    typedef logic [7:0] seg_t;

    // Dropped frames, saturating.
    typedef logic [7:0] err_count_t;

    typedef enum logic [1:0] {
        SHOW_ON_RELEASE = 2'd0,
        SHOW_ON_PRESS   = 2'd1
    } disp_mode_t;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        BREAK_WAIT = 2'd1,
        HOLD       = 2'd2
    } dec_state_t;

    // Byte handed from the receiver to the decoder.
    typedef struct packed {
        logic       valid;
        scan_code_t code;
    } scan_byte_t;

    // Display configuration.
    typedef struct packed {
        disp_mode_t mode;
        logic       blank;
    } cfg_t;

    // A key release is announced by this prefix.
    localparam scan_code_t BREAK_PREFIX = 8'hF0;

endpackage
